/* common/fetch_cfg.svh */
// ----------------------------
// fetch stage configuration macros
// include wherever prefetch depth or the
// reset pc is needed
// ----------------------------
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// queued plus outstanding words held by the prefetch buffer
`define FETCH_PREFETCH_DEPTH 4

// value of pc_id_o out of reset
`define FETCH_BOOT_ADDR_RST 32'h0000_0000

`endif

/* common/fetch_pkg.sv */
// ----------------------------
// shared types for the fetch stage
// pc mux and exception mux selects, offset FSM states
// and the two views of a fetched instruction word
// used by the fetch RTL and its testbench
// ----------------------------
`default_nettype none

package fetch_pkg;

  // next fetch address source, driven by the controller
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_BRANCH    = 3'd2,
    PC_EXCEPTION = 3'd3,
    PC_MRET      = 3'd4,
    PC_DRET      = 3'd5,
    PC_FENCEI    = 3'd6
  } pc_mux_e;

  // handler address form
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'd0,  // common trap entry
    EXC_PC_IRQ       = 2'd1,  // vectored interrupt
    EXC_PC_DBD       = 2'd2   // debug halt
  } exc_pc_mux_e;

  typedef enum logic [0:0] {
    IDLE = 1'b0,  // nothing requested yet
    WAIT = 1'b1   // serving words from the prefetch buffer
  } offset_state_e;

  // ----------------------------
  // instruction word views
  // ----------------------------
  typedef struct packed {
    logic [6:0] funct7;   // [31:25]
    logic [4:0] rs2;      // [24:20]
    logic [4:0] rs1;      // [19:15]
    logic [2:0] funct3;   // [14:12]
    logic [4:0] rd;       // [11:7]
    logic [6:0] opcode;   // [6:0]
  } instr_full_t;

  typedef struct packed {
    logic [15:0] upper;     // unused half of the word
    logic [2:0]  funct3;    // [15:13]
    logic        bit12;     // [12], selects mv/add in quadrant 2
    logic [4:0]  rd_rs1;    // [11:7]
    logic [4:0]  rs2;       // [6:2]
    logic [1:0]  quadrant;  // 2'b11 means not compressed
  } instr_comp_t;

  typedef union packed {
    instr_full_t full;  // 32-bit view
    instr_comp_t c;     // compressed view of the low half
  } instr_word_u;

endpackage

`default_nettype wire

/* src/pc_select.sv */
// ----------------------------
// next fetch address selection
// purely combinational, feeds the prefetch buffer
// whenever the fetch stage issues a branch
// ----------------------------
`timescale 1ns/10ps
`default_nettype none

module pc_select (
  input  fetch_pkg::pc_mux_e     pc_mux_i,
  input  fetch_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  logic [31:0]            boot_addr_i,
  input  logic [31:0]            jump_target_i,
  input  logic [31:0]            branch_target_i,
  input  logic [31:0]            mepc_i,
  input  logic [31:0]            depc_i,
  input  logic [31:0]            pc_id_i,          // pc of the word sitting in ID
  input  logic [23:0]            trap_base_addr_i,
  input  logic [4:0]             irq_id_i,
  input  logic [29:0]            dm_halt_addr_i,
  output logic [31:0]            fetch_addr_o
);

  logic [31:0] exc_pc;    // handler address
  logic [31:0] addr_sel;  // raw mux output before alignment

  // ----------------------------
  // exception vector
  // ----------------------------
  always_comb begin
    case (exc_pc_mux_i)
      fetch_pkg::EXC_PC_EXCEPTION: exc_pc = {trap_base_addr_i, 8'h00};
      // vectored irqs, one word per id
      fetch_pkg::EXC_PC_IRQ:       exc_pc = {trap_base_addr_i, 1'b0, irq_id_i, 2'b00};
      fetch_pkg::EXC_PC_DBD:       exc_pc = {dm_halt_addr_i, 2'b00};
      default:                     exc_pc = {trap_base_addr_i, 8'h00};
    endcase
  end

  // ----------------------------
  // fetch address mux
  // ----------------------------
  always_comb begin
    case (pc_mux_i)
      fetch_pkg::PC_BOOT:      addr_sel = boot_addr_i;
      fetch_pkg::PC_JUMP:      addr_sel = jump_target_i;
      fetch_pkg::PC_BRANCH:    addr_sel = branch_target_i;
      fetch_pkg::PC_EXCEPTION: addr_sel = exc_pc;
      fetch_pkg::PC_MRET:      addr_sel = mepc_i;    // return from trap
      fetch_pkg::PC_DRET:      addr_sel = depc_i;    // return from debug
      // refetch the word after fence.i so stale prefetched data is dropped
      fetch_pkg::PC_FENCEI:    addr_sel = pc_id_i + 32'd4;
      default:                 addr_sel = boot_addr_i;
    endcase
  end

  // fetch is word granular
  assign fetch_addr_o = {addr_sel[31:2], 2'b00};

endmodule

`default_nettype wire

/* prefetch/prefetch_buffer.sv */
// ----------------------------
// prefetch buffer for the fetch stage
// issues word requests on the req/gnt/rvalid bus,
// queues responses with address and error flag,
// flushes and discards stale responses on a branch
// ----------------------------
`timescale 1ns/10ps
`default_nettype none
`include "fetch_cfg.svh"

module prefetch_buffer (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,           // fetching enabled
  input  logic        branch_i,        // redirect to addr_i
  input  logic [31:0] addr_i,
  input  logic        ready_i,         // consumer takes the head word
  output logic        valid_o,
  output logic [31:0] rdata_o,
  output logic [31:0] addr_o,
  output logic        err_o,
  output logic        instr_req_o,
  output logic [31:0] instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  logic [31:0] instr_rdata_i,
  input  logic        instr_err_i,
  output logic        busy_o
);

  localparam int DEPTH = `FETCH_PREFETCH_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // queue storage
  logic [31:0]      fifo_data_q [DEPTH];
  logic [31:0]      fifo_addr_q [DEPTH];
  logic             fifo_err_q  [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q, count_n;      // queued words
  logic [CNT_W-1:0] out_cnt_q, out_cnt_n;  // granted, response pending
  logic [CNT_W-1:0] discard_q, discard_n;  // pending responses to drop
  logic [CNT_W:0]   credit_n;              // in flight after this cycle
  logic             req_q, req_n;
  logic [31:0]      req_addr_q;            // address on the bus
  logic [31:0]      next_addr_q;           // address of the next new request
  logic [31:0]      resp_addr_q;           // address of the next kept response
  logic [31:0]      issue_addr;
  logic             granted, drop, push, pop, raise;

  // ----------------------------
  // bookkeeping
  // ----------------------------
  assign granted = req_q & instr_gnt_i;
  assign drop    = instr_rvalid_i & (branch_i | (discard_q != '0));  // stale response
  assign push    = instr_rvalid_i & ~drop;
  assign pop     = valid_o & ready_i & ~branch_i;

  assign out_cnt_n = out_cnt_q + CNT_W'(granted) - CNT_W'(instr_rvalid_i);

  always_comb begin
    if (branch_i) begin
      count_n   = '0;  // queue emptied
      // everything granted or still raised belongs to the old stream
      discard_n = out_cnt_n + CNT_W'(req_q & ~instr_gnt_i);
    end else begin
      count_n   = count_q + CNT_W'(push) - CNT_W'(pop);
      discard_n = discard_q - CNT_W'(instr_rvalid_i & (discard_q != '0));
    end
  end

  assign credit_n   = {1'b0, out_cnt_n} + {1'b0, count_n};
  assign issue_addr = branch_i ? addr_i : next_addr_q;
  // a raised request is never dropped, a new one needs a free slot
  assign raise = req_i & (~req_q | instr_gnt_i) & (credit_n < (CNT_W+1)'(DEPTH));
  assign req_n = (req_q & ~instr_gnt_i) | raise;

  // ----------------------------
  // control registers
  // ----------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q       <= 1'b0;
      req_addr_q  <= '0;
      next_addr_q <= '0;
      resp_addr_q <= '0;
      count_q     <= '0;
      out_cnt_q   <= '0;
      discard_q   <= '0;
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
    end else begin
      req_q     <= req_n;
      count_q   <= count_n;
      out_cnt_q <= out_cnt_n;
      discard_q <= discard_n;
      if (raise) begin
        req_addr_q  <= issue_addr;
        next_addr_q <= issue_addr + 32'd4;
      end else if (branch_i) begin
        next_addr_q <= addr_i;  // held request finishes first
      end
      if (branch_i) begin
        resp_addr_q <= addr_i;
        wr_ptr_q    <= '0;
        rd_ptr_q    <= '0;
      end else begin
        if (push) begin
          resp_addr_q <= resp_addr_q + 32'd4;
          wr_ptr_q    <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // queue write
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_data_q[wr_ptr_q] <= instr_rdata_i;
      fifo_addr_q[wr_ptr_q] <= resp_addr_q;
      fifo_err_q[wr_ptr_q]  <= instr_err_i;
    end
  end

  assign valid_o      = (count_q != '0);
  assign rdata_o      = fifo_data_q[rd_ptr_q];
  assign addr_o       = fifo_addr_q[rd_ptr_q];
  assign err_o        = fifo_err_q[rd_ptr_q];
  assign instr_req_o  = req_q;
  assign instr_addr_o = req_addr_q;
  assign busy_o       = req_q | (out_cnt_q != '0);

endmodule

`default_nettype wire

/* src/compressed_expander.sv */
// ----------------------------
// rvc expander for the supported subset
// c.addi c.li c.lw c.sw c.j c.mv c.add
// other compressed forms are flagged illegal
// and passed through unchanged
// ----------------------------
`timescale 1ns/10ps
`default_nettype none

module compressed_expander (
  input  fetch_pkg::instr_word_u instr_i,
  output logic [31:0]            instr_o,
  output logic                   is_compressed_o,
  output logic                   illegal_o
);

  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  logic [15:0]            ci;       // raw halfword for immediate scatter
  logic                   is_c;
  logic                   illegal;
  fetch_pkg::instr_word_u exp_w;    // expanded word, written through the 32-bit view

  assign ci   = instr_i[15:0];
  assign is_c = (instr_i.c.quadrant != 2'b11);

  always_comb begin
    exp_w   = instr_i;  // unchanged unless a supported form matches
    illegal = 1'b0;
    if (is_c) begin
      case ({instr_i.c.quadrant, instr_i.c.funct3})
        // ----------------------------
        // quadrant 0
        // ----------------------------
        5'b00_010: begin  // c.lw -> lw rd', imm(rs1')
          {exp_w.full.funct7, exp_w.full.rs2} = {5'b0, ci[5], ci[12:10], ci[6], 2'b00};
          exp_w.full.rs1    = {2'b01, ci[9:7]};
          exp_w.full.funct3 = 3'b010;
          exp_w.full.rd     = {2'b01, ci[4:2]};
          exp_w.full.opcode = OPC_LOAD;
        end
        5'b00_110: begin  // c.sw -> sw rs2', imm(rs1')
          exp_w.full.funct7 = {5'b0, ci[5], ci[12]};
          exp_w.full.rs2    = {2'b01, ci[4:2]};
          exp_w.full.rs1    = {2'b01, ci[9:7]};
          exp_w.full.funct3 = 3'b010;
          exp_w.full.rd     = {ci[11:10], ci[6], 2'b00};  // imm[4:0]
          exp_w.full.opcode = OPC_STORE;
        end
        // ----------------------------
        // quadrant 1
        // ----------------------------
        5'b01_000: begin  // c.addi -> addi rd, rd, imm
          {exp_w.full.funct7, exp_w.full.rs2} = {{7{ci[12]}}, ci[6:2]};
          exp_w.full.rs1    = instr_i.c.rd_rs1;
          exp_w.full.funct3 = 3'b000;
          exp_w.full.rd     = instr_i.c.rd_rs1;
          exp_w.full.opcode = OPC_OP_IMM;
        end
        5'b01_010: begin  // c.li -> addi rd, x0, imm
          {exp_w.full.funct7, exp_w.full.rs2} = {{7{ci[12]}}, ci[6:2]};
          exp_w.full.rs1    = 5'd0;
          exp_w.full.funct3 = 3'b000;
          exp_w.full.rd     = instr_i.c.rd_rs1;
          exp_w.full.opcode = OPC_OP_IMM;
        end
        5'b01_101: begin  // c.j -> jal x0, offset
          {exp_w.full.funct7, exp_w.full.rs2, exp_w.full.rs1, exp_w.full.funct3} =
            {ci[12], ci[8], ci[10:9], ci[6], ci[7], ci[2], ci[11], ci[5:3],
             ci[12], {8{ci[12]}}};
          exp_w.full.rd     = 5'd0;
          exp_w.full.opcode = OPC_JAL;
        end
        // ----------------------------
        // quadrant 2
        // ----------------------------
        5'b10_100: begin
          if (instr_i.c.rs2 != 5'd0) begin  // c.mv or c.add
            exp_w.full.funct7 = 7'b0;
            exp_w.full.rs2    = instr_i.c.rs2;
            exp_w.full.rs1    = instr_i.c.bit12 ? instr_i.c.rd_rs1 : 5'd0;
            exp_w.full.funct3 = 3'b000;
            exp_w.full.rd     = instr_i.c.rd_rs1;
            exp_w.full.opcode = OPC_OP;
          end else begin
            illegal = 1'b1;  // c.jr, c.jalr, c.ebreak
          end
        end
        default: illegal = 1'b1;
      endcase
    end
  end

  assign instr_o         = exp_w;
  assign is_compressed_o = is_c;
  assign illegal_o       = illegal;

endmodule

`default_nettype wire

/* src/fetch_stage.sv */
// ----------------------------
// instruction fetch stage top
// pc selection, prefetch buffer, rvc expansion,
// offset FSM and the IF/ID pipeline registers
// IF/ID outputs freeze while ID back-pressures
// ----------------------------
`timescale 1ns/10ps
`default_nettype none
`include "fetch_cfg.svh"

module fetch_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  input  logic                   pc_set_i,          // redirect request
  input  fetch_pkg::pc_mux_e     pc_mux_i,
  input  fetch_pkg::exc_pc_mux_e exc_pc_mux_i,
  input  logic [31:0]            boot_addr_i,
  input  logic [31:0]            jump_target_i,
  input  logic [31:0]            branch_target_i,
  input  logic [31:0]            mepc_i,
  input  logic [31:0]            depc_i,
  input  logic [23:0]            trap_base_addr_i,
  input  logic [4:0]             irq_id_i,
  input  logic [29:0]            dm_halt_addr_i,
  output logic                   instr_req_o,
  output logic [31:0]            instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  logic [31:0]            instr_rdata_i,
  input  logic                   instr_err_i,
  input  logic                   id_ready_i,
  input  logic                   halt_if_i,
  input  logic                   clear_instr_valid_i,
  output logic                   instr_valid_id_o,
  output logic [31:0]            instr_rdata_id_o,
  output logic                   is_compressed_id_o,
  output logic                   illegal_c_insn_id_o,
  output logic [31:0]            pc_id_o,
  output logic [31:0]            pc_if_o,
  output logic                   fetch_err_id_o,
  output logic                   if_busy_o,
  output logic                   perf_imiss_o
);

  fetch_pkg::offset_state_e state_q, state_n;

  logic        branch_req, valid, if_valid;
  logic [31:0] fetch_addr_n;
  logic        fetch_valid, fetch_ready, fetch_err;
  logic [31:0] fetch_rdata, fetch_addr;
  logic        prefetch_busy;
  logic [31:0] instr_exp;
  logic        instr_is_c, instr_illegal;

  pc_select u_pc_select (
    .pc_mux_i(pc_mux_i), .exc_pc_mux_i(exc_pc_mux_i), .boot_addr_i(boot_addr_i),
    .jump_target_i(jump_target_i), .branch_target_i(branch_target_i),
    .mepc_i(mepc_i), .depc_i(depc_i), .pc_id_i(pc_id_o),
    .trap_base_addr_i(trap_base_addr_i), .irq_id_i(irq_id_i),
    .dm_halt_addr_i(dm_halt_addr_i), .fetch_addr_o(fetch_addr_n)
  );

  prefetch_buffer u_prefetch (
    .clk(clk), .rst_n(rst_n), .req_i(req_i), .branch_i(branch_req),
    .addr_i(fetch_addr_n), .ready_i(fetch_ready), .valid_o(fetch_valid),
    .rdata_o(fetch_rdata), .addr_o(fetch_addr), .err_o(fetch_err),
    .instr_req_o(instr_req_o), .instr_addr_o(instr_addr_o),
    .instr_gnt_i(instr_gnt_i), .instr_rvalid_i(instr_rvalid_i),
    .instr_rdata_i(instr_rdata_i), .instr_err_i(instr_err_i), .busy_o(prefetch_busy)
  );

  compressed_expander u_expander (
    .instr_i(fetch_rdata), .instr_o(instr_exp),
    .is_compressed_o(instr_is_c), .illegal_o(instr_illegal)
  );

  // ----------------------------
  // offset FSM
  // ----------------------------
  always_comb begin
    state_n    = state_q;
    branch_req = 1'b0;
    valid      = 1'b0;
    case (state_q)
      fetch_pkg::IDLE: if (req_i) begin  // first fetch starts at the selected pc
        branch_req = 1'b1;
        state_n    = fetch_pkg::WAIT;
      end
      fetch_pkg::WAIT: valid = fetch_valid;
      default:         state_n = fetch_pkg::IDLE;
    endcase
    if (pc_set_i) begin  // redirect wins over everything
      valid      = 1'b0;
      branch_req = 1'b1;
      state_n    = fetch_pkg::WAIT;
    end
  end

  assign if_valid    = valid & id_ready_i & ~halt_if_i;  // transfer into ID
  assign fetch_ready = if_valid;                         // pop on transfer only

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state_q <= fetch_pkg::IDLE;
    else        state_q <= state_n;
  end

  // ----------------------------
  // IF/ID pipeline registers
  // ----------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_id_o    <= 1'b0;
      is_compressed_id_o  <= 1'b0;
      illegal_c_insn_id_o <= 1'b0;
      fetch_err_id_o      <= 1'b0;
      pc_id_o             <= `FETCH_BOOT_ADDR_RST;
    end else if (if_valid) begin
      instr_valid_id_o    <= 1'b1;
      is_compressed_id_o  <= instr_is_c;
      illegal_c_insn_id_o <= instr_illegal;
      fetch_err_id_o      <= fetch_err;
      pc_id_o             <= fetch_addr;
    end else if (clear_instr_valid_i) begin
      instr_valid_id_o    <= 1'b0;  // ID consumed it, keep the rest
    end
  end

  always_ff @(posedge clk) begin
    if (if_valid) instr_rdata_id_o <= instr_exp;
  end

  assign pc_if_o      = fetch_addr;
  assign if_busy_o    = prefetch_busy;
  assign perf_imiss_o = ~fetch_valid | branch_req;  // starved or redirecting

endmodule

`default_nettype wire

/* sim/instr_mem_model.sv */
// ----------------------------
// instruction memory for the fetch testbench
// answers req/gnt/rvalid in order, grant and response
// gated each cycle by enables from the testbench
// words inside [ERR_LO, ERR_HI] come back with err set
// ----------------------------
`timescale 1ns/10ps
`default_nettype none
`include "fetch_cfg.svh"

module instr_mem_model #(
  parameter logic [31:0] ERR_LO = 32'h0000_0200,
  parameter logic [31:0] ERR_HI = 32'h0000_027c
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  input  logic        gnt_en_i,   // random grant delay
  input  logic        rsp_en_i,   // random response delay
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_o
);

  logic [31:0] mem [256];    // image, filled by the testbench
  logic [31:0] pend_q [8];   // granted addresses awaiting a response
  logic [2:0]  wr_q, rd_q;
  logic [3:0]  cnt_q;
  logic        pop;

  assign gnt_o = req_i & gnt_en_i & (cnt_q < 4'(`FETCH_PREFETCH_DEPTH));
  assign pop   = (cnt_q != 4'd0) & rsp_en_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      err_o    <= 1'b0;
      wr_q     <= '0;
      rd_q     <= '0;
      cnt_q    <= '0;
    end else begin
      rvalid_o <= pop;
      if (pop) begin  // oldest grant answers first
        rdata_o <= mem[pend_q[rd_q][9:2]];
        err_o   <= (pend_q[rd_q] >= ERR_LO) && (pend_q[rd_q] <= ERR_HI);
        rd_q    <= rd_q + 3'd1;
      end
      if (gnt_o) begin
        pend_q[wr_q] <= addr_i;
        wr_q         <= wr_q + 3'd1;
      end
      cnt_q <= cnt_q + 4'(gnt_o) - 4'(pop);
    end
  end

endmodule

`default_nettype wire

/* sim/fetch_tb.sv */
// ----------------------------
// testbench for the fetch stage
// random memory image and bus delays from a galois lfsr,
// redirects over every pc mux value, ID back-pressure,
// each accepted word compared against a reference expansion
// ----------------------------
`timescale 1ns/10ps
`default_nettype none
`include "fetch_cfg.svh"

module fetch_tb;

  localparam logic [31:0] ERR_LO = 32'h0000_0200;
  localparam logic [31:0] ERR_HI = 32'h0000_027c;
  localparam logic [31:0] BOOT   = 32'h0000_0100;

  logic clk = 1'b0;
  logic rst_n, req_i, pc_set_i, id_ready_i, halt_if_i, clear_instr_valid_i;
  fetch_pkg::pc_mux_e     pc_mux_i;
  fetch_pkg::exc_pc_mux_e exc_pc_mux_i;
  logic [31:0] boot_addr_i, jump_target_i, branch_target_i, mepc_i, depc_i;
  logic [23:0] trap_base_addr_i;
  logic [4:0]  irq_id_i;
  logic [29:0] dm_halt_addr_i;
  logic        instr_req_o, instr_gnt, instr_rvalid, instr_err, gnt_en, rsp_en;
  logic [31:0] instr_addr_o, instr_rdata, instr_rdata_id_o, pc_id_o, pc_if_o;
  logic        instr_valid_id_o, is_compressed_id_o, illegal_c_insn_id_o;
  logic        fetch_err_id_o, if_busy_o, perf_imiss_o;

  logic [31:0] lfsr_state = 32'h1f47a258;
  logic [31:0] pend_target, cyc_target, cyc_pc_if, exp_pc, prev_pc, prev_rdata;
  logic        cyc_run, cyc_set, cyc_stall, cyc_imiss, timed_out, stall_halt;
  logic        prev_valid;
  int          errors, accepted, stall_left;

  always #10 clk = ~clk;  // 20 ns period

  fetch_stage UUT (
    .clk(clk), .rst_n(rst_n), .req_i(req_i), .pc_set_i(pc_set_i),
    .pc_mux_i(pc_mux_i), .exc_pc_mux_i(exc_pc_mux_i), .boot_addr_i(boot_addr_i),
    .jump_target_i(jump_target_i), .branch_target_i(branch_target_i),
    .mepc_i(mepc_i), .depc_i(depc_i), .trap_base_addr_i(trap_base_addr_i),
    .irq_id_i(irq_id_i), .dm_halt_addr_i(dm_halt_addr_i),
    .instr_req_o(instr_req_o), .instr_addr_o(instr_addr_o), .instr_gnt_i(instr_gnt),
    .instr_rvalid_i(instr_rvalid), .instr_rdata_i(instr_rdata), .instr_err_i(instr_err),
    .id_ready_i(id_ready_i), .halt_if_i(halt_if_i),
    .clear_instr_valid_i(clear_instr_valid_i), .instr_valid_id_o(instr_valid_id_o),
    .instr_rdata_id_o(instr_rdata_id_o), .is_compressed_id_o(is_compressed_id_o),
    .illegal_c_insn_id_o(illegal_c_insn_id_o), .pc_id_o(pc_id_o), .pc_if_o(pc_if_o),
    .fetch_err_id_o(fetch_err_id_o), .if_busy_o(if_busy_o), .perf_imiss_o(perf_imiss_o)
  );

  instr_mem_model #(.ERR_LO(ERR_LO), .ERR_HI(ERR_HI)) u_mem (
    .clk(clk), .rst_n(rst_n), .req_i(instr_req_o), .addr_i(instr_addr_o),
    .gnt_en_i(gnt_en), .rsp_en_i(rsp_en), .gnt_o(instr_gnt),
    .rvalid_o(instr_rvalid), .rdata_o(instr_rdata), .err_o(instr_err)
  );

  // ----------------------------
  // random source
  // ----------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};  // one step per bit
    end
  endtask

  // ----------------------------
  // reference models
  // ----------------------------
  // returns {is_compressed, illegal, expanded word}
  function automatic logic [33:0] expand_word(input fetch_pkg::instr_word_u w);
    logic [15:0] h;
    logic [4:0]  rdp, rs1p;
    logic [6:0]  uimm;
    logic [11:0] simm;
    logic [20:0] joff;
    logic [31:0] r;
    logic        ill;
    h    = w[15:0];
    rdp  = {2'b01, h[4:2]};
    rs1p = {2'b01, h[9:7]};
    uimm = {h[5], h[12:10], h[6], 2'b00};       // word offset for lw/sw
    simm = {{7{h[12]}}, h[6:2]};
    joff = {{10{h[12]}}, h[8], h[10:9], h[6], h[7], h[2], h[11], h[5:3], 1'b0};
    r    = w;
    ill  = 1'b0;
    if (w.c.quadrant == 2'b11) return {2'b00, r};  // plain 32-bit word
    case ({w.c.quadrant, w.c.funct3})
      5'b00_010: r = {5'b0, uimm, rs1p, 3'b010, rdp, 7'h03};
      5'b00_110: r = {5'b0, uimm[6:5], rdp, rs1p, 3'b010, uimm[4:0], 7'h23};
      5'b01_000: r = {simm, w.c.rd_rs1, 3'b000, w.c.rd_rs1, 7'h13};
      5'b01_010: r = {simm, 5'd0, 3'b000, w.c.rd_rs1, 7'h13};
      5'b01_101: r = {joff[20], joff[10:1], joff[11], joff[19:12], 5'd0, 7'h6f};
      5'b10_100: begin
        if (w.c.rs2 != 5'd0) begin
          r = {7'b0, w.c.rs2, (w.c.bit12 ? w.c.rd_rs1 : 5'd0), 3'b000, w.c.rd_rs1, 7'h33};
        end else begin
          ill = 1'b1;
        end
      end
      default: ill = 1'b1;
    endcase
    return {1'b1, ill, r};
  endfunction

  function automatic logic [31:0] redirect_target(input logic [2:0] m, input logic [1:0] e);
    logic [31:0] v;
    case (m)
      3'd1:    v = jump_target_i;
      3'd2:    v = branch_target_i;
      3'd3:    v = (e == 2'd1) ? {trap_base_addr_i, 1'b0, irq_id_i, 2'b00} :
                   (e == 2'd2) ? {dm_halt_addr_i, 2'b00} : {trap_base_addr_i, 8'h00};
      3'd4:    v = mepc_i;
      3'd5:    v = depc_i;
      3'd6:    v = pc_id_o + 32'd4;  // fence.i refetches after the ID word
      default: v = boot_addr_i;
    endcase
    v[1:0] = 2'b00;
    return v;
  endfunction

  // inputs and status seen by the last rising edge
  always @(posedge clk) begin
    cyc_run    <= rst_n;
    cyc_set    <= pc_set_i;
    cyc_target <= pend_target;
    cyc_stall  <= ~id_ready_i | halt_if_i;
    cyc_pc_if  <= pc_if_o;       // head word address in that cycle
    cyc_imiss  <= perf_imiss_o;
  end

  // ----------------------------
  // comparing process
  // ----------------------------
  always @(negedge clk) begin : compare
    logic [33:0] exp_w;
    logic        exp_err;
    if (cyc_run) begin
      exp_w   = expand_word(u_mem.mem[exp_pc[9:2]]);
      exp_err = (exp_pc >= ERR_LO) && (exp_pc <= ERR_HI);
      if (cyc_set) begin
        assert (!instr_valid_id_o) else begin
          errors++;
          $display("word accepted in a redirect cycle at pc %h", pc_id_o);
        end
        assert (cyc_imiss === 1'b1) else begin
          errors++;
          $display("[ERROR] perf_imiss_o got %h exp 1 in a redirect cycle", cyc_imiss);
        end
        exp_pc = cyc_target;  // old stream must not show up again
      end else if (cyc_stall) begin
        assert (instr_valid_id_o === prev_valid && pc_id_o === prev_pc
                && instr_rdata_id_o === prev_rdata)
        else begin
          errors++;
          $display(
            "[ERROR] stall instr_valid_id_o %h/%h pc_id_o %h/%h instr_rdata_id_o %h/%h",
            instr_valid_id_o, prev_valid, pc_id_o, prev_pc, instr_rdata_id_o, prev_rdata);
        end
      end else if (instr_valid_id_o) begin
        assert (pc_id_o === exp_pc) else begin
          errors++;
          $display("[ERROR] pc_id_o got %h exp %h", pc_id_o, exp_pc);
        end
        assert (cyc_pc_if === exp_pc) else begin
          errors++;
          $display("[ERROR] pc_if_o got %h exp %h", cyc_pc_if, exp_pc);
        end
        assert (cyc_imiss === 1'b0) else begin
          errors++;
          $display("[ERROR] perf_imiss_o got %h exp 0 in a transfer cycle", cyc_imiss);
        end
        assert (instr_rdata_id_o === exp_w[31:0]) else begin
          errors++;
          $display("[ERROR] instr_rdata_id_o got %h exp %h", instr_rdata_id_o, exp_w[31:0]);
        end
        assert ({is_compressed_id_o, illegal_c_insn_id_o} === exp_w[33:32]) else begin
          errors++;
          $display("[ERROR] is_compressed_id_o/illegal_c_insn_id_o got %h exp %h",
                   {is_compressed_id_o, illegal_c_insn_id_o}, exp_w[33:32]);
        end
        assert (fetch_err_id_o === exp_err) else begin
          errors++;
          $display("[ERROR] fetch_err_id_o got %h exp %h", fetch_err_id_o, exp_err);
        end
        exp_pc = exp_pc + 32'd4;
        accepted++;
      end
      prev_valid = instr_valid_id_o;
      prev_pc    = pc_id_o;
      prev_rdata = instr_rdata_id_o;
    end
  end

  // ----------------------------
  // stimulus
  // ----------------------------
  task automatic drive_cycle(input bit stalls);
    logic [31:0] r;
    @(negedge clk);
    draw(4, r);
    gnt_en              = (r[1:0] != 2'b00);
    rsp_en              = (r[3:2] != 2'b00);
    pc_set_i            = 1'b0;
    id_ready_i          = 1'b1;
    halt_if_i           = 1'b0;
    clear_instr_valid_i = 1'b1;  // ID drains its word unless stalled
    if (stalls && stall_left == 0) begin
      draw(5, r);
      if (r[4:3] == 2'b00) begin  // start a stretch of 2..5 cycles
        stall_left = int'(r[1:0]) + 2;
        stall_halt = r[2];
      end
    end
    if (stall_left != 0) begin
      stall_left--;
      clear_instr_valid_i = 1'b0;
      if (stall_halt) halt_if_i = 1'b1;
      else            id_ready_i = 1'b0;
    end
  endtask

  task automatic run_until(input int target, input bit stalls);
    int guard;
    guard = 0;
    while (!timed_out && accepted < target) begin
      drive_cycle(stalls);
      guard++;
      if (guard > 3000) begin
        timed_out = 1'b1;
        $display("timeout: no progress toward %0d accepted words", target);
      end
    end
  endtask

  task automatic redirect(input logic [2:0] m, input logic [1:0] e);
    logic [31:0] r;
    @(negedge clk);
    draw(10, r);
    jump_target_i = r;
    draw(10, r);
    branch_target_i = r;
    draw(10, r);
    mepc_i = r;
    draw(10, r);
    depc_i = r;
    draw(2, r);
    trap_base_addr_i = r[23:0];
    draw(5, r);
    irq_id_i = r[4:0];
    draw(8, r);
    dm_halt_addr_i = r[29:0];
    pc_mux_i            = fetch_pkg::pc_mux_e'(m);
    exc_pc_mux_i        = fetch_pkg::exc_pc_mux_e'(e);
    pend_target         = redirect_target(m, e);
    pc_set_i            = 1'b1;
    id_ready_i          = 1'b1;
    halt_if_i           = 1'b0;
    clear_instr_valid_i = 1'b1;
  endtask

  initial begin : stimulus
    logic [31:0] w, k;
    rst_n               = 1'b0;
    req_i               = 1'b0;
    pc_set_i            = 1'b0;
    id_ready_i          = 1'b1;
    halt_if_i           = 1'b0;
    clear_instr_valid_i = 1'b1;
    pc_mux_i            = fetch_pkg::PC_BOOT;
    exc_pc_mux_i        = fetch_pkg::EXC_PC_EXCEPTION;
    boot_addr_i         = BOOT;
    jump_target_i       = '0;
    branch_target_i     = '0;
    mepc_i              = '0;
    depc_i              = '0;
    trap_base_addr_i    = '0;
    irq_id_i            = '0;
    dm_halt_addr_i      = '0;
    gnt_en              = 1'b0;
    rsp_en              = 1'b0;
    pend_target         = '0;
    errors              = 0;
    accepted            = 0;
    stall_left          = 0;
    stall_halt          = 1'b0;
    timed_out           = 1'b0;
    exp_pc              = BOOT;
    prev_valid          = 1'b0;
    prev_pc             = `FETCH_BOOT_ADDR_RST;
    prev_rdata          = '0;
    // image mixes 32-bit, supported and random compressed words
    for (int i = 0; i < 256; i++) begin
      draw(2, k);
      draw(32, w);
      case (k[1:0])
        2'd0: w[1:0] = 2'b11;
        2'd1: begin
          draw(3, k);
          case (k[2:0])
            3'd0:    {w[15:13], w[1:0]} = 5'b010_00;  // c.lw
            3'd1:    {w[15:13], w[1:0]} = 5'b110_00;  // c.sw
            3'd2:    {w[15:13], w[1:0]} = 5'b000_01;  // c.addi
            3'd3:    {w[15:13], w[1:0]} = 5'b010_01;  // c.li
            3'd4:    {w[15:13], w[1:0]} = 5'b101_01;  // c.j
            default: begin  // c.mv / c.add
              {w[15:13], w[1:0]} = 5'b100_10;
              w[2] = 1'b1;
            end
          endcase
        end
        2'd2: if (w[1:0] == 2'b11) w[1:0] = 2'b00;
        default: ;
      endcase
      u_mem.mem[i] = w;
    end
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      assert (!instr_req_o && !instr_valid_id_o && !if_busy_o) else begin
        errors++;
        $display("outputs active during reset");
      end
    end
    rst_n = 1'b1;
    @(negedge clk);
    assert (!instr_req_o && !instr_valid_id_o && !if_busy_o
            && pc_id_o === `FETCH_BOOT_ADDR_RST) else begin
      errors++;
      $display("[ERROR] after reset pc_id_o %h req %h valid %h busy %h",
               pc_id_o, instr_req_o, instr_valid_id_o, if_busy_o);
    end
    req_i = 1'b1;
    run_until(40, 1'b0);  // sequential fetch from boot
    for (int m = 0; m < 7; m++) begin
      for (int j = 0; j < 3; j++) begin
        if (!timed_out) redirect(3'(m), (m == 3) ? 2'(j) : 2'd0);
        run_until(accepted + 3, 1'b0);
      end
    end
    run_until(accepted + 80, 1'b1);  // back-pressure stretches
    for (int m = 0; m < 7; m++) begin
      if (!timed_out) redirect(3'(m), 2'd1);
      run_until(accepted + 3, 1'b1);
    end
    $display("errors: %0d, words checked: %0d", errors, accepted);
    if (errors == 0 && !timed_out) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+common
common/fetch_pkg.sv
src/pc_select.sv
prefetch/prefetch_buffer.sv
src/compressed_expander.sv
src/fetch_stage.sv
sim/instr_mem_model.sv
sim/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the fetch stage testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f list.f --top-module fetch_tb -o fetch_tb_sim
./obj_dir/fetch_tb_sim | tee sim.log

if grep -q "Verification passed" sim.log; then
  exit 0
else
  exit 1
fi
